//--- design/access_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module access_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk_i,
  input  logic     reset,
  access_if.buffer acc
);
  import trig_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  mem_access_t      mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign push = acc.wr_en && !acc.full;
  assign pop  = acc.rd_en && !acc.empty;

  assign acc.full    = (count_q == CNT_W'(FIFO_DEPTH));
  assign acc.empty   = (count_q == '0);
  assign acc.rd_item = mem_q[rd_ptr_q];

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk_i) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= acc.wr_item;
    end
  end

endmodule

`default_nettype wire

//--- design/access_if.sv
`timescale 1ns/1ps
`default_nettype none

interface access_if;
  import trig_pkg::*;

  // Write side, fed by the splitter
  logic        wr_en;
  mem_access_t wr_item;
  logic        full;

  // Read side, drained by the matcher
  logic        rd_en;
  mem_access_t rd_item;
  logic        empty;

  modport producer (output wr_en, output wr_item, input full);

  modport buffer (input wr_en, input wr_item, input rd_en,
                  output full, output rd_item, output empty);

  modport consumer (output rd_en, input rd_item, input empty);

endinterface

`default_nettype wire

//--- design/mem_op_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_op_splitter #(
  parameter int MAX_OPS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset,
  input  logic                   retire_valid,
  input  logic                   retire_exception,
  input  logic                   retire_exec_hit,
  input  logic [3:0]             retire_num_ops,
  input  logic [MAX_OPS*32-1:0]  retire_addr,
  input  logic [MAX_OPS*4-1:0]   retire_rmask,
  input  logic [MAX_OPS*4-1:0]   retire_wmask,
  output logic                   busy,
  access_if.producer             acc
);
  import trig_pkg::*;

  localparam int IDX_W = (MAX_OPS > 1) ? $clog2(MAX_OPS) : 1;

  split_state_e               state_q;
  logic [3:0]                 op_idx_q;
  logic [3:0]                 last_q;
  logic [MAX_OPS-1:0][31:0]   addr_q;
  logic [MAX_OPS-1:0][3:0]    rmask_q;
  logic [MAX_OPS-1:0][3:0]    wmask_q;
  logic [3:0]                 num_ops_clamped;
  logic                       accept;
  mem_access_t                item_d;

  // Trapped or execute-hit instructions carry no data accesses
  assign accept = retire_valid && !busy && !retire_exception && !retire_exec_hit &&
                  (retire_num_ops != 4'd0);

  assign num_ops_clamped = (retire_num_ops > 4'(MAX_OPS)) ? 4'(MAX_OPS) : retire_num_ops;

  assign busy = (state_q == ST_SPLIT);

  always_ff @(posedge clk_i) begin
    if (reset) begin
      state_q  <= ST_IDLE;
      op_idx_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q  <= ST_SPLIT;
            op_idx_q <= '0;
          end
        end
        ST_SPLIT: begin
          if (acc.wr_en) begin
            if (op_idx_q == last_q) state_q <= ST_IDLE;
            op_idx_q <= op_idx_q + 4'd1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Operation vectors of the accepted instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= retire_addr;
      rmask_q <= retire_rmask;
      wmask_q <= retire_wmask;
      last_q  <= num_ops_clamped - 4'd1;
    end
  end

  always_comb begin
    item_d.addr     = addr_q[op_idx_q[IDX_W-1:0]];
    item_d.rmask    = rmask_q[op_idx_q[IDX_W-1:0]];
    item_d.wmask    = wmask_q[op_idx_q[IDX_W-1:0]];
    item_d.op_index = op_idx_q;
  end

  // The item stays put while the FIFO is full
  assign acc.wr_en   = busy && !acc.full;
  assign acc.wr_item = item_d;

endmodule

`default_nettype wire

//--- design/trig_csr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module trig_csr_bank #(
  parameter int NUM_TRIGGERS = 4
) (
  input  logic                            clk_i,
  input  logic                            reset,
  input  logic                            csr_we,
  input  logic [$clog2(NUM_TRIGGERS)-1:0] csr_sel,
  input  trig_pkg::csr_reg_e              csr_reg,
  input  logic [31:0]                     csr_wdata,
  output logic [31:0]                     csr_rdata,
  output trig_pkg::trig_cfg_t             cfg [NUM_TRIGGERS]
);
  import trig_pkg::*;

  logic sel_ok;

  // A select beyond the last trigger neither writes nor reads anything
  assign sel_ok = int'(csr_sel) < NUM_TRIGGERS;

  always_ff @(posedge clk_i) begin
    if (reset) begin
      for (int i = 0; i < NUM_TRIGGERS; i++) begin
        cfg[i] <= '0;
      end
    end else if (csr_we && sel_ok) begin
      if (csr_reg == REG_TDATA1) begin
        cfg[csr_sel].tdata1 <= csr_wdata;
      end else begin
        cfg[csr_sel].tdata2 <= csr_wdata;
      end
    end
  end

  always_comb begin
    csr_rdata = '0;
    if (sel_ok) begin
      if (csr_reg == REG_TDATA1) begin
        csr_rdata = cfg[csr_sel].tdata1;
      end else begin
        csr_rdata = cfg[csr_sel].tdata2;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/trig_mem_match.sv
`timescale 1ns/1ps
`default_nettype none

module trig_mem_match #(
  parameter int NUM_TRIGGERS = 4
) (
  input  logic                    clk_i,
  input  logic                    reset,
  input  trig_pkg::trig_cfg_t     cfg [NUM_TRIGGERS],
  access_if.consumer              acc,
  output logic                    match_valid,
  output logic [NUM_TRIGGERS-1:0] match_vec,
  output logic [3:0]              match_op_index
);
  import trig_pkg::*;

  logic [3:0][31:0]             byte_addr;
  logic [3:0]                   in_first;
  logic [3:0][NUM_TRIGGERS-1:0] byte_hits;
  logic [NUM_TRIGGERS-1:0]      first_vec;
  logic [NUM_TRIGGERS-1:0]      all_vec;
  logic [NUM_TRIGGERS-1:0]      match_d;
  logic                         pop;

  // One byte against one trigger
  function automatic logic trig_byte_hit(trig_cfg_t c, logic [31:0] addr,
                                         logic rd, logic wr);
    logic dir_ok;
    logic addr_ok;
    dir_ok = (c.tdata1[TDATA1_LOAD] && rd) || (c.tdata1[TDATA1_STORE] && wr);
    case (match_mode_e'(c.tdata1[TDATA1_MATCH_MSB:TDATA1_MATCH_LSB]))
      MATCH_EQUAL: addr_ok = (addr == c.tdata2);
      MATCH_GE:    addr_ok = (addr >= c.tdata2);
      MATCH_LT:    addr_ok = (addr < c.tdata2);
      default:     addr_ok = 1'b0;
    endcase
    return c.tdata1[TDATA1_ENABLE] && dir_ok && addr_ok;
  endfunction

  // The matcher never stalls, so it takes the head whenever there is one
  assign acc.rd_en = !acc.empty;
  assign pop       = !acc.empty;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      byte_addr[b] = acc.rd_item.addr + 32'(b);
    end
  end

  // Bytes sharing the word of byte 0 form a contiguous run from byte 0
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      in_first[b] = (byte_addr[b][31:2] == byte_addr[0][31:2]);
    end
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      for (int t = 0; t < NUM_TRIGGERS; t++) begin
        byte_hits[b][t] = trig_byte_hit(cfg[t], byte_addr[b],
                                        acc.rd_item.rmask[b], acc.rd_item.wmask[b]);
      end
    end
  end

  // A hit in the first word masks out any hit in the next word
  always_comb begin
    first_vec = '0;
    all_vec   = '0;
    for (int b = 0; b < 4; b++) begin
      all_vec = all_vec | byte_hits[b];
      if (in_first[b]) begin
        first_vec = first_vec | byte_hits[b];
      end
    end
    match_d = (|first_vec) ? first_vec : all_vec;
  end

  always_ff @(posedge clk_i) begin
    if (reset) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      match_vec      <= match_d;
      match_op_index <= acc.rd_item.op_index;
    end
  end

endmodule

`default_nettype wire

//--- design/trig_pkg.sv
`default_nettype none

package trig_pkg;

  // Match field encodings of tdata1 for the supported modes
  typedef enum logic [3:0] {
    MATCH_EQUAL = 4'd0,
    MATCH_GE    = 4'd2,
    MATCH_LT    = 4'd3
  } match_mode_e;

  // Register select on the CSR port
  typedef enum logic {
    REG_TDATA1 = 1'b0,
    REG_TDATA2 = 1'b1
  } csr_reg_e;

  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_SPLIT = 1'b1
  } split_state_e;

  // Bit positions inside tdata1
  localparam int TDATA1_LOAD      = 0;
  localparam int TDATA1_STORE     = 1;
  localparam int TDATA1_ENABLE    = 6;
  localparam int TDATA1_MATCH_LSB = 7;
  localparam int TDATA1_MATCH_MSB = 10;

  typedef struct packed {
    logic [31:0] tdata1;
    logic [31:0] tdata2;
  } trig_cfg_t;

  // One memory operation of a retired instruction
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [3:0]  op_index;
  } mem_access_t;

endpackage

`default_nettype wire

//--- design/trig_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module trig_unit_top #(
  parameter int NUM_TRIGGERS = 4,
  parameter int MAX_OPS      = 4,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic                            clk_i,
  input  logic                            reset,
  input  logic                            retire_valid,
  input  logic                            retire_exception,
  input  logic                            retire_exec_hit,
  input  logic [3:0]                      retire_num_ops,
  input  logic [MAX_OPS*32-1:0]           retire_addr,
  input  logic [MAX_OPS*4-1:0]            retire_rmask,
  input  logic [MAX_OPS*4-1:0]            retire_wmask,
  input  logic                            csr_we,
  input  logic [$clog2(NUM_TRIGGERS)-1:0] csr_sel,
  input  trig_pkg::csr_reg_e              csr_reg,
  input  logic [31:0]                     csr_wdata,
  output logic [31:0]                     csr_rdata,
  output logic                            busy,
  output logic                            match_valid,
  output logic [NUM_TRIGGERS-1:0]         match_vec,
  output logic [3:0]                      match_op_index
);
  import trig_pkg::*;

  trig_cfg_t cfg [NUM_TRIGGERS];

  access_if acc_if ();

  trig_csr_bank #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_trig_csr_bank (
    .clk_i     (clk_i),
    .reset     (reset),
    .csr_we    (csr_we),
    .csr_sel   (csr_sel),
    .csr_reg   (csr_reg),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .cfg       (cfg)
  );

  mem_op_splitter #(.MAX_OPS(MAX_OPS)) i_mem_op_splitter (
    .clk_i            (clk_i),
    .reset            (reset),
    .retire_valid     (retire_valid),
    .retire_exception (retire_exception),
    .retire_exec_hit  (retire_exec_hit),
    .retire_num_ops   (retire_num_ops),
    .retire_addr      (retire_addr),
    .retire_rmask     (retire_rmask),
    .retire_wmask     (retire_wmask),
    .busy             (busy),
    .acc              (acc_if.producer)
  );

  access_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_access_fifo (
    .clk_i (clk_i),
    .reset (reset),
    .acc   (acc_if.buffer)
  );

  trig_mem_match #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_trig_mem_match (
    .clk_i          (clk_i),
    .reset          (reset),
    .cfg            (cfg),
    .acc            (acc_if.consumer),
    .match_valid    (match_valid),
    .match_vec      (match_vec),
    .match_op_index (match_op_index)
  );

endmodule

`default_nettype wire

//--- files.f
design/trig_pkg.sv
design/access_if.sv
design/trig_csr_bank.sv
design/mem_op_splitter.sv
design/access_fifo.sv
design/trig_mem_match.sv
design/trig_unit_top.sv
verif/tb_trig_unit.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_trig_unit -f files.f -o sim_trig_unit
./obj_dir/sim_trig_unit | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation passed"

//--- verif/tb_trig_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trig_unit;
  import trig_pkg::*;

  localparam int NUM_TRIG = 4;
  localparam int MAX_OPS  = 4;
  localparam int SEL_W    = $clog2(NUM_TRIG);
  // Instructions issued over all six tests add up to 4 + 12 + 4 + 5 + 6 + 200
  localparam int NUM_INSTR      = 231;
  localparam int TIMEOUT_CYCLES = 40 * NUM_INSTR + 200;

  logic                  clk_i = 1'b0;
  logic                  reset;
  logic                  retire_valid;
  logic                  retire_exception;
  logic                  retire_exec_hit;
  logic [3:0]            retire_num_ops;
  logic [MAX_OPS*32-1:0] retire_addr;
  logic [MAX_OPS*4-1:0]  retire_rmask;
  logic [MAX_OPS*4-1:0]  retire_wmask;
  logic                  csr_we;
  logic [SEL_W-1:0]      csr_sel;
  csr_reg_e              csr_reg;
  logic [31:0]           csr_wdata;
  logic [31:0]           csr_rdata;
  logic                  busy;
  logic                  match_valid;
  logic [NUM_TRIG-1:0]   match_vec;
  logic [3:0]            match_op_index;

  integer              seed = 84043;
  int                  errors = 0;
  int                  tests_passed = 0;
  int                  tests_failed = 0;
  int                  test_err_start = 0;
  int                  cycles = 0;
  trig_cfg_t           cfg_model [NUM_TRIG];
  logic [NUM_TRIG-1:0] exp_vec_q [$];
  logic [3:0]          exp_idx_q [$];

  trig_unit_top i_trig_unit_top (
    .clk_i (clk_i), .reset (reset),
    .retire_valid (retire_valid), .retire_exception (retire_exception),
    .retire_exec_hit (retire_exec_hit), .retire_num_ops (retire_num_ops),
    .retire_addr (retire_addr), .retire_rmask (retire_rmask), .retire_wmask (retire_wmask),
    .csr_we (csr_we), .csr_sel (csr_sel), .csr_reg (csr_reg), .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata), .busy (busy), .match_valid (match_valid),
    .match_vec (match_vec), .match_op_index (match_op_index)
  );

  always #20 clk_i = ~clk_i;

  // Byte rule per trigger, then the aligned-word reduction
  function automatic logic [NUM_TRIG-1:0] expected_match(input trig_cfg_t cfgs [NUM_TRIG],
                                                         input mem_access_t a);
    logic [NUM_TRIG-1:0] first_hits;
    logic [NUM_TRIG-1:0] any_hits;
    logic [31:0]         ba;
    logic [3:0]          mode;
    logic                dir_ok;
    logic                addr_ok;
    int                  first_len;
    first_hits = '0;
    any_hits = '0;
    // Bytes left in the word of byte 0, also right when the address wraps
    first_len = 4 - int'(a.addr[1:0]);
    for (int b = 0; b < 4; b++) begin
      for (int t = 0; t < NUM_TRIG; t++) begin
        ba = a.addr + 32'(b);
        mode = cfgs[t].tdata1[TDATA1_MATCH_MSB:TDATA1_MATCH_LSB];
        dir_ok = (a.rmask[b] && cfgs[t].tdata1[TDATA1_LOAD]) ||
                 (a.wmask[b] && cfgs[t].tdata1[TDATA1_STORE]);
        if (mode == MATCH_EQUAL) addr_ok = (ba == cfgs[t].tdata2);
        else if (mode == MATCH_GE) addr_ok = (ba >= cfgs[t].tdata2);
        else if (mode == MATCH_LT) addr_ok = (ba < cfgs[t].tdata2);
        else addr_ok = 1'b0;
        if (cfgs[t].tdata1[TDATA1_ENABLE] && dir_ok && addr_ok) begin
          any_hits[t] = 1'b1;
          if (b < first_len) first_hits[t] = 1'b1;
        end
      end
    end
    return (first_hits != '0) ? first_hits : any_hits;
  endfunction

  function automatic logic [31:0] make_tdata1(input logic en, input logic ld, input logic st,
                                              input logic [3:0] mode);
    logic [31:0] v;
    v = '0;
    v[TDATA1_ENABLE] = en;
    v[TDATA1_LOAD] = ld;
    v[TDATA1_STORE] = st;
    v[TDATA1_MATCH_MSB:TDATA1_MATCH_LSB] = mode;
    return v;
  endfunction

  task automatic check_vec(input logic [NUM_TRIG-1:0] exp, input logic [NUM_TRIG-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: match_vec expected %b, got %b", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_index(input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: match_op_index expected %0d, got %0d",
               $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_rdata(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: csr_rdata expected %h, got %h", $time, exp, act);
      errors++;
    end
  endtask

  task automatic check_busy(input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: busy expected %b, got %b", $time, exp, act);
      errors++;
    end
  endtask

  task automatic csr_write(input int sel, input csr_reg_e which, input logic [31:0] data);
    @(negedge clk_i);
    csr_we = 1'b1;
    csr_sel = SEL_W'(sel);
    csr_reg = which;
    csr_wdata = data;
    @(negedge clk_i);
    csr_we = 1'b0;
    if (which == REG_TDATA1) cfg_model[sel].tdata1 = data;
    else cfg_model[sel].tdata2 = data;
  endtask

  task automatic read_check(input int sel, input csr_reg_e which, input logic [31:0] exp);
    @(negedge clk_i);
    csr_we = 1'b0;
    csr_sel = SEL_W'(sel);
    csr_reg = which;
    @(posedge clk_i);
    check_rdata(exp, csr_rdata);
  endtask

  task automatic set_trigger(input int t, input logic [31:0] d1, input logic [31:0] d2);
    csr_write(t, REG_TDATA1, d1);
    csr_write(t, REG_TDATA2, d2);
  endtask

  // Waits for busy low, strobes one instruction and queues its expected results
  task automatic retire(input int num, input logic [MAX_OPS*32-1:0] addrs,
                        input logic [MAX_OPS*4-1:0] rm, input logic [MAX_OPS*4-1:0] wm,
                        input logic exc, input logic hit);
    int          n_ops;
    mem_access_t a;
    @(negedge clk_i);
    while (busy) @(negedge clk_i);
    retire_valid = 1'b1;
    retire_exception = exc;
    retire_exec_hit = hit;
    retire_num_ops = 4'(num);
    retire_addr = addrs;
    retire_rmask = rm;
    retire_wmask = wm;
    n_ops = 0;
    if (!exc && !hit) begin
      n_ops = (num > MAX_OPS) ? MAX_OPS : num;
      for (int i = 0; i < n_ops; i++) begin
        a.addr = addrs[i*32 +: 32];
        a.rmask = rm[i*4 +: 4];
        a.wmask = wm[i*4 +: 4];
        a.op_index = 4'(i);
        exp_vec_q.push_back(expected_match(cfg_model, a));
        exp_idx_q.push_back(4'(i));
      end
    end
    @(negedge clk_i);
    retire_valid = 1'b0;
    // Only an instruction with operations to split raises busy in the next cycle
    check_busy(n_ops != 0, busy);
  endtask

  task automatic retire_one(input logic [31:0] addr, input logic [3:0] rm, input logic [3:0] wm);
    retire(1, {96'h0, addr}, {12'h0, rm}, {12'h0, wm}, 1'b0, 1'b0);
  endtask

  task automatic retire_random();
    logic [31:0]           r;
    logic [31:0]           m;
    logic [MAX_OPS*32-1:0] addrs;
    r = $random(seed);
    m = $random(seed);
    for (int i = 0; i < MAX_OPS; i++) begin
      addrs[i*32 +: 32] = 32'h3FF8 + ($unsigned($random(seed)) % 32'h110);
    end
    // Up to 5 operations so the clamp to MAX_OPS and the empty case are covered
    retire(int'(r[2:0]) % 6, addrs, m[15:0], m[31:16], r[5:3] == 3'd0, r[8:6] == 3'd0);
  endtask

  task automatic random_config();
    logic [31:0] r;
    logic [3:0]  mode;
    for (int t = 0; t < NUM_TRIG; t++) begin
      r = $random(seed);
      case (r[5:4])
        2'd0: mode = MATCH_EQUAL;
        2'd1: mode = MATCH_GE;
        2'd2: mode = MATCH_LT;
        default: mode = 4'd1;
      endcase
      set_trigger(t, make_tdata1(r[3:2] != 2'd0, r[0], r[1], mode),
                  32'h4000 + ($unsigned($random(seed)) % 32'h100));
    end
  endtask

  task automatic end_test(input string name);
    int waited;
    waited = 0;
    while ((exp_vec_q.size() != 0 || busy) && waited < 100) begin
      @(negedge clk_i);
      waited++;
    end
    // A few more cycles catch results that should not exist
    repeat (4) @(negedge clk_i);
    if (exp_vec_q.size() != 0) begin
      $display("ERROR: %0d expected results never arrived in test %s", exp_vec_q.size(), name);
      errors++;
      exp_vec_q.delete();
      exp_idx_q.delete();
    end
    if (errors == test_err_start) begin
      $display("Test %s: PASS", name);
      tests_passed++;
    end else begin
      $display("Test %s: FAIL", name);
      tests_failed++;
    end
    test_err_start = errors;
  endtask

  // Scoreboard
  always @(negedge clk_i) begin
    if (!reset && match_valid) begin
      if (exp_vec_q.size() == 0) begin
        $display("ERROR at time %0t: match_valid pulsed with no result expected", $time);
        errors++;
      end else begin
        check_vec(exp_vec_q.pop_front(), match_vec);
        check_index(exp_idx_q.pop_front(), match_op_index);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles with %0d results pending", cycles,
               exp_vec_q.size());
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0]           probe [6];
    logic [31:0]           d1;
    logic [31:0]           d2;
    logic [MAX_OPS*32-1:0] addrs;
    reset = 1'b1;
    retire_valid = 1'b0;
    retire_exception = 1'b0;
    retire_exec_hit = 1'b0;
    retire_num_ops = '0;
    retire_addr = '0;
    retire_rmask = '0;
    retire_wmask = '0;
    csr_we = 1'b0;
    csr_sel = '0;
    csr_reg = REG_TDATA1;
    csr_wdata = '0;
    for (int t = 0; t < NUM_TRIG; t++) cfg_model[t] = '0;
    repeat (4) @(negedge clk_i);
    reset = 1'b0;

    // Test 1 covers reset values, disabled triggers and register read back
    check_busy(1'b0, busy);
    for (int t = 0; t < NUM_TRIG; t++) read_check(t, REG_TDATA1, 32'h0);
    for (int i = 0; i < 4; i++) retire_one($random(seed), 4'hF, 4'hF);
    for (int t = 0; t < NUM_TRIG; t++) begin
      d1 = $random(seed);
      d2 = $random(seed);
      set_trigger(t, d1, d2);
      read_check(t, REG_TDATA1, d1);
      read_check(t, REG_TDATA2, d2);
    end
    end_test("1 register access");

    // Test 2 tries each mode and the load and store gating on single bytes
    set_trigger(0, make_tdata1(1'b1, 1'b1, 1'b0, MATCH_EQUAL), 32'h1000);
    set_trigger(1, make_tdata1(1'b1, 1'b0, 1'b1, MATCH_GE), 32'h2000);
    set_trigger(2, make_tdata1(1'b1, 1'b1, 1'b1, MATCH_LT), 32'h0800);
    set_trigger(3, make_tdata1(1'b0, 1'b1, 1'b1, MATCH_EQUAL), 32'h1000);
    probe[0] = 32'h1000;
    probe[1] = 32'h0FFF;
    probe[2] = 32'h2000;
    probe[3] = 32'h1FFF;
    probe[4] = 32'h07FF;
    probe[5] = 32'h0800;
    for (int i = 0; i < 6; i++) begin
      retire_one(probe[i], 4'b0001, 4'b0000);
      retire_one(probe[i], 4'b0000, 4'b0001);
    end
    end_test("2 match modes");

    // Test 3 uses accesses crossing into the next word
    set_trigger(0, make_tdata1(1'b1, 1'b1, 1'b0, MATCH_EQUAL), 32'h3004);
    set_trigger(1, make_tdata1(1'b1, 1'b1, 1'b0, MATCH_EQUAL), 32'h3002);
    set_trigger(2, make_tdata1(1'b1, 1'b1, 1'b0, MATCH_GE), 32'h3004);
    retire_one(32'h3001, 4'b1111, 4'b0000);
    retire_one(32'h3001, 4'b1001, 4'b0000);
    retire_one(32'h3003, 4'b0011, 4'b0000);
    retire_one(32'h3002, 4'b1111, 4'b0000);
    end_test("3 aligned word");

    // Test 4 mixes multi-operation instructions with dropped ones
    for (int i = 0; i < MAX_OPS; i++) addrs[i*32 +: 32] = 32'h2FFE + 32'(i);
    retire(3, addrs, 16'hFFFF, 16'h0000, 1'b0, 1'b0);
    retire(4, addrs, 16'h0F0F, 16'hF0F0, 1'b0, 1'b0);
    retire(4, addrs, 16'hFFFF, 16'hFFFF, 1'b1, 1'b0);
    retire(2, addrs, 16'hFFFF, 16'hFFFF, 1'b0, 1'b1);
    retire(2, addrs, 16'h00FF, 16'h0000, 1'b0, 1'b0);
    end_test("4 splitting");

    // Test 5 retires full-width instructions back to back
    for (int n = 0; n < 6; n++) begin
      for (int i = 0; i < MAX_OPS; i++) addrs[i*32 +: 32] = 32'h2FFC + ($random(seed) & 32'hF);
      retire(MAX_OPS, addrs, 16'hFFFF, 16'(n * 16'h1111), 1'b0, 1'b0);
    end
    end_test("5 back-pressure");

    // Test 6 runs random traffic with a new configuration every 20 instructions
    for (int blk = 0; blk < 10; blk++) begin
      random_config();
      for (int i = 0; i < 20; i++) retire_random();
      end_test($sformatf("6 random block %0d", blk));
    end

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
